// ==== src/exu_pkg.sv ====
package exu_pkg;

  localparam int xlen = 32;
  localparam int muldiv_steps = 32;
  localparam int step_count_width = 6;

  typedef enum logic [4:0] {
    op_add,
    op_sub,
    op_sll,
    op_slt,
    op_sltu,
    op_xor,
    op_srl,
    op_sra,
    op_or,
    op_and,
    op_eq,
    op_ne,
    op_lt,
    op_ge,
    op_ltu,
    op_geu,
    op_pass_b,
    op_mul,
    op_mulh,
    op_mulhsu,
    op_mulhu,
    op_div,
    op_divu,
    op_rem,
    op_remu
  } exu_op_e;

  // The immediate is only a legal source for operand2.
  typedef enum logic [1:0] {
    sel_reg_value,
    sel_immediate,
    sel_self_forward,
    sel_ext_forward
  } operand_sel_e;

  typedef enum logic [1:0] {
    npc_seq,
    npc_jal,
    npc_jalr,
    npc_branch
  } npc_sel_e;

  typedef enum logic [1:0] {
    wb_alu_result,
    wb_pc_plus4,
    wb_pc_plus_imm
  } wb_sel_e;

  typedef enum logic [1:0] {
    md_idle,
    md_run,
    md_finish
  } muldiv_state_e;

  function automatic logic is_muldiv(exu_op_e op);
    return op inside {op_mul, op_mulh, op_mulhsu, op_mulhu,
                      op_div, op_divu, op_rem, op_remu};
  endfunction

endpackage

// ==== src/exu_issue_if.sv ====
`timescale 1ns/10ps

interface exu_issue_if;
  import exu_pkg::*;

  logic valid;
  exu_op_e op;
  logic [xlen-1:0] operand_a;
  logic [xlen-1:0] operand_b;

  modport source (
    output valid,
    output op,
    output operand_a,
    output operand_b
  );

  modport alu (
    input op,
    input operand_a,
    input operand_b
  );

  modport muldiv (
    input valid,
    input op,
    input operand_a,
    input operand_b
  );

endinterface

// ==== src/exu_operand_select.sv ====
`timescale 1ns/10ps

module exu_operand_select (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       flush,
  input  logic                       accept,
  input  logic [exu_pkg::xlen-1:0]   pc,
  input  logic [exu_pkg::xlen-1:0]   imm,
  input  logic [exu_pkg::xlen-1:0]   src1,
  input  logic [exu_pkg::xlen-1:0]   src2,
  input  logic [exu_pkg::xlen-1:0]   forward_data,
  input  exu_pkg::exu_op_e           op,
  input  exu_pkg::operand_sel_e      op1_sel,
  input  exu_pkg::operand_sel_e      op2_sel,
  input  exu_pkg::npc_sel_e          npc_sel_in,
  input  exu_pkg::wb_sel_e           wb_sel_in,
  input  logic [exu_pkg::xlen-1:0]   last_result,
  exu_issue_if.source                issue,
  output logic [exu_pkg::xlen-1:0]   pc_plus4,
  output logic [exu_pkg::xlen-1:0]   pc_plus_imm,
  output logic [exu_pkg::xlen-1:0]   pc_reg,
  output exu_pkg::npc_sel_e          npc_sel,
  output exu_pkg::wb_sel_e           wb_sel
);
  import exu_pkg::*;

  logic [xlen-1:0] operand_a_next;
  logic [xlen-1:0] operand_b_next;

  always_comb begin
    case (op1_sel)
      sel_self_forward: operand_a_next = last_result;
      sel_ext_forward:  operand_a_next = forward_data;
      default:          operand_a_next = src1;
    endcase
    case (op2_sel)
      sel_immediate:    operand_b_next = imm;
      sel_self_forward: operand_b_next = last_result;
      sel_ext_forward:  operand_b_next = forward_data;
      default:          operand_b_next = src2;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      issue.valid <= 1'b0;
    end else begin
      issue.valid <= accept;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      issue.op <= op;
      issue.operand_a <= operand_a_next;
      issue.operand_b <= operand_b_next;
      pc_reg <= pc;
      pc_plus4 <= pc + 32'd4;
      pc_plus_imm <= pc + imm;
      npc_sel <= npc_sel_in;
      wb_sel <= wb_sel_in;
    end
  end

endmodule

// ==== src/exu_alu.sv ====
`timescale 1ns/10ps

module exu_alu (
  exu_issue_if.alu                  issue,
  output logic [exu_pkg::xlen-1:0]  result
);
  import exu_pkg::*;

  logic [xlen-1:0] a;
  logic [xlen-1:0] b;
  logic [4:0] shamt;
  logic signed_lt;
  logic unsigned_lt;

  assign a = issue.operand_a;
  assign b = issue.operand_b;
  assign shamt = b[4:0];
  assign signed_lt = $signed(a) < $signed(b);
  assign unsigned_lt = a < b;

  always_comb begin
    result = '0;
    case (issue.op)
      op_add:    result = a + b;
      op_sub:    result = a - b;
      op_sll:    result = a << shamt;
      op_slt:    result = {31'd0, signed_lt};
      op_sltu:   result = {31'd0, unsigned_lt};
      op_xor:    result = a ^ b;
      op_srl:    result = a >> shamt;
      op_sra:    result = $signed(a) >>> shamt;
      op_or:     result = a | b;
      op_and:    result = a & b;
      // Branch compares leave their outcome in bit 0 for the next-PC logic.
      op_eq:     result = {31'd0, a == b};
      op_ne:     result = {31'd0, a != b};
      op_lt:     result = {31'd0, signed_lt};
      op_ge:     result = {31'd0, !signed_lt};
      op_ltu:    result = {31'd0, unsigned_lt};
      op_geu:    result = {31'd0, !unsigned_lt};
      op_pass_b: result = b;
      default:   result = '0;
    endcase
  end

endmodule

// ==== src/exu_next_pc.sv ====
`timescale 1ns/10ps

module exu_next_pc (
  input  exu_pkg::npc_sel_e          npc_sel,
  input  exu_pkg::wb_sel_e           wb_sel,
  input  logic [exu_pkg::xlen-1:0]   pc_plus4,
  input  logic [exu_pkg::xlen-1:0]   pc_plus_imm,
  input  logic [exu_pkg::xlen-1:0]   alu_result,
  output logic [exu_pkg::xlen-1:0]   next_pc,
  output logic [exu_pkg::xlen-1:0]   wb_data,
  output logic                       redirect_taken
);
  import exu_pkg::*;

  always_comb begin
    case (npc_sel)
      npc_jal:    next_pc = pc_plus_imm;
      // Target of jalr is rs1 + imm with bit 0 cleared.
      npc_jalr:   next_pc = {alu_result[xlen-1:1], 1'b0};
      npc_branch: next_pc = alu_result[0] ? pc_plus_imm : pc_plus4;
      default:    next_pc = pc_plus4;
    endcase
  end

  always_comb begin
    case (wb_sel)
      wb_pc_plus4:    wb_data = pc_plus4;
      wb_pc_plus_imm: wb_data = pc_plus_imm;
      default:        wb_data = alu_result;
    endcase
  end

  // The front end always fetches PC+4, so anything else is a misprediction.
  assign redirect_taken = next_pc != pc_plus4;

endmodule

// ==== src/exu_muldiv_fsm.sv ====
`timescale 1ns/10ps

module exu_muldiv_fsm (
  input  logic          clock,
  input  logic          reset,
  input  logic          flush,
  exu_issue_if.muldiv   issue,
  input  logic          steps_done,
  output logic          load,
  output logic          step,
  output logic          busy,
  output logic          done
);
  import exu_pkg::*;

  muldiv_state_e state;
  muldiv_state_e state_next;

  always_comb begin
    state_next = state;
    load = 1'b0;
    step = 1'b0;
    done = 1'b0;
    case (state)
      md_idle: begin
        if (issue.valid && is_muldiv(issue.op)) begin
          load = 1'b1;
          state_next = md_run;
        end
      end
      md_run: begin
        step = 1'b1;
        if (steps_done) begin
          state_next = md_finish;
        end
      end
      md_finish: begin
        done = 1'b1;
        state_next = md_idle;
      end
      default: state_next = md_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      state <= md_idle;
    end else begin
      state <= state_next;
    end
  end

  // Busy already covers the load cycle so decode cannot overwrite the issue registers.
  assign busy = load || (state != md_idle);

endmodule

// ==== src/exu_step_counter.sv ====
`timescale 1ns/10ps

module exu_step_counter (
  input  logic clock,
  input  logic reset,
  input  logic load,
  input  logic step,
  output logic steps_done
);
  import exu_pkg::*;

  logic [step_count_width-1:0] count;

  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      count <= step_count_width'(muldiv_steps);
    end else if (step && count != '0) begin
      count <= count - 1'b1;
    end
  end

  // Fires together with the last step.
  assign steps_done = step && (count == step_count_width'(1));

endmodule

// ==== src/exu_muldiv_datapath.sv ====
`timescale 1ns/10ps

module exu_muldiv_datapath (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       load,
  input  logic                       step,
  exu_issue_if.muldiv                issue,
  output logic [exu_pkg::xlen-1:0]   result
);
  import exu_pkg::*;

  logic a_signed;
  logic b_signed;
  logic neg_a;
  logic neg_b;
  logic [xlen-1:0] mag_a;
  logic [xlen-1:0] mag_b;

  exu_op_e op_q;
  logic is_div_q;
  logic neg_a_q;
  logic neg_b_q;
  logic div_zero_q;
  logic div_ovf_q;
  logic [xlen-1:0] dividend_q;
  logic [xlen-1:0] divisor_q;
  logic [2*xlen-1:0] acc;

  logic [xlen:0] mul_sum;
  logic [xlen:0] rem_shift;
  logic [xlen+1:0] rem_diff;
  logic [2*xlen-1:0] product;
  logic [xlen-1:0] quotient;
  logic [xlen-1:0] remainder;

  // The low word of mul is sign independent, so mul runs unsigned.
  assign a_signed = issue.op inside {op_mulh, op_mulhsu, op_div, op_rem};
  assign b_signed = issue.op inside {op_mulh, op_div, op_rem};
  assign neg_a = a_signed && issue.operand_a[xlen-1];
  assign neg_b = b_signed && issue.operand_b[xlen-1];
  assign mag_a = neg_a ? -issue.operand_a : issue.operand_a;
  assign mag_b = neg_b ? -issue.operand_b : issue.operand_b;

  always_ff @(posedge clock) begin
    if (reset) begin
      op_q <= op_mul;
      is_div_q <= 1'b0;
      neg_a_q <= 1'b0;
      neg_b_q <= 1'b0;
      div_zero_q <= 1'b0;
      div_ovf_q <= 1'b0;
    end else if (load) begin
      op_q <= issue.op;
      is_div_q <= issue.op inside {op_div, op_divu, op_rem, op_remu};
      neg_a_q <= neg_a;
      neg_b_q <= neg_b;
      div_zero_q <= issue.operand_b == '0;
      div_ovf_q <= (issue.op inside {op_div, op_rem}) &&
                   (issue.operand_a == {1'b1, {(xlen-1){1'b0}}}) &&
                   (issue.operand_b == '1);
    end
  end

  // Multiply adds the multiplicand into the high half; divide keeps a 33-bit partial remainder.
  assign mul_sum = {1'b0, acc[2*xlen-1:xlen]} + (acc[0] ? {1'b0, divisor_q} : {(xlen+1){1'b0}});
  assign rem_shift = acc[2*xlen-1:xlen-1];
  assign rem_diff = {1'b0, rem_shift} - {2'b00, divisor_q};

  always_ff @(posedge clock) begin
    if (load) begin
      dividend_q <= issue.operand_a;
      divisor_q <= mag_b;
      acc <= {{xlen{1'b0}}, mag_a};
    end else if (step) begin
      if (!is_div_q) begin
        acc <= {mul_sum, acc[xlen-1:1]};
      end else if (!rem_diff[xlen+1]) begin
        acc <= {rem_diff[xlen-1:0], acc[xlen-2:0], 1'b1};
      end else begin
        acc <= {rem_shift[xlen-1:0], acc[xlen-2:0], 1'b0};
      end
    end
  end

  assign product = (neg_a_q ^ neg_b_q) ? -acc : acc;
  assign quotient = (neg_a_q ^ neg_b_q) ? -acc[xlen-1:0] : acc[xlen-1:0];
  assign remainder = neg_a_q ? -acc[2*xlen-1:xlen] : acc[2*xlen-1:xlen];

  always_comb begin
    case (op_q)
      op_mul:                         result = product[xlen-1:0];
      op_mulh, op_mulhsu, op_mulhu:   result = product[2*xlen-1:xlen];
      op_div, op_divu: begin
        if (div_zero_q) result = '1;
        else if (div_ovf_q) result = dividend_q;
        else result = quotient;
      end
      op_rem, op_remu: begin
        if (div_zero_q) result = dividend_q;
        else if (div_ovf_q) result = '0;
        else result = remainder;
      end
      default:                        result = '0;
    endcase
  end

endmodule

// ==== src/exu_top.sv ====
`timescale 1ns/10ps

module exu_top (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   decode_valid,
  input  logic                   flush,
  input  logic [31:0]            pc,
  input  logic [31:0]            imm,
  input  logic [31:0]            src1,
  input  logic [31:0]            src2,
  input  logic [31:0]            forward_data,
  input  exu_pkg::exu_op_e       op,
  input  exu_pkg::operand_sel_e  op1_sel,
  input  exu_pkg::operand_sel_e  op2_sel,
  input  exu_pkg::npc_sel_e      npc_sel,
  input  exu_pkg::wb_sel_e       wb_sel,
  output logic                   busy,
  output logic                   result_valid,
  output logic                   redirect,
  output logic [31:0]            result,
  output logic [31:0]            next_pc,
  output logic [31:0]            result_pc
);
  import exu_pkg::*;

  logic accept;
  logic alu_issue;
  logic [xlen-1:0] last_result;
  logic [xlen-1:0] result_hold;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] pc_plus_imm;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] wb_data;
  logic [xlen-1:0] muldiv_result;
  logic redirect_taken;
  npc_sel_e npc_sel_q;
  wb_sel_e wb_sel_q;
  logic load;
  logic step;
  logic steps_done;
  logic done;

  exu_issue_if issue_bus ();

  assign accept = decode_valid && !busy && !flush;

  exu_operand_select i_operand_select (
    .clock        (clock),
    .reset        (reset),
    .flush        (flush),
    .accept       (accept),
    .pc           (pc),
    .imm          (imm),
    .src1         (src1),
    .src2         (src2),
    .forward_data (forward_data),
    .op           (op),
    .op1_sel      (op1_sel),
    .op2_sel      (op2_sel),
    .npc_sel_in   (npc_sel),
    .wb_sel_in    (wb_sel),
    .last_result  (last_result),
    .issue        (issue_bus.source),
    .pc_plus4     (pc_plus4),
    .pc_plus_imm  (pc_plus_imm),
    .pc_reg       (result_pc),
    .npc_sel      (npc_sel_q),
    .wb_sel       (wb_sel_q)
  );

  exu_alu i_alu (
    .issue  (issue_bus.alu),
    .result (alu_result)
  );

  exu_next_pc i_next_pc (
    .npc_sel        (npc_sel_q),
    .wb_sel         (wb_sel_q),
    .pc_plus4       (pc_plus4),
    .pc_plus_imm    (pc_plus_imm),
    .alu_result     (alu_result),
    .next_pc        (next_pc),
    .wb_data        (wb_data),
    .redirect_taken (redirect_taken)
  );

  exu_muldiv_fsm i_muldiv_fsm (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .issue      (issue_bus.muldiv),
    .steps_done (steps_done),
    .load       (load),
    .step       (step),
    .busy       (busy),
    .done       (done)
  );

  exu_step_counter i_step_counter (
    .clock      (clock),
    .reset      (reset),
    .load       (load),
    .step       (step),
    .steps_done (steps_done)
  );

  exu_muldiv_datapath i_muldiv_datapath (
    .clock  (clock),
    .reset  (reset),
    .load   (load),
    .step   (step),
    .issue  (issue_bus.muldiv),
    .result (muldiv_result)
  );

  assign alu_issue = issue_bus.valid && !is_muldiv(issue_bus.op);
  assign result_valid = alu_issue || done;
  assign redirect = result_valid && redirect_taken;
  assign result = done ? muldiv_result : wb_data;

  // A dependent instruction issued right behind its producer takes the live result.
  always_ff @(posedge clock) begin
    if (result_valid) begin
      result_hold <= result;
    end
  end

  assign last_result = result_valid ? result : result_hold;

endmodule

// ==== verif/exu_tb_tests.svh ====
// Presents one instruction for a single accept edge.
task automatic issue_op(input exu_op_e o, input operand_sel_e s1, input operand_sel_e s2,
                        input logic [31:0] a, input logic [31:0] b, input logic [31:0] im,
                        input logic [31:0] p, input npc_sel_e ns, input wb_sel_e ws);
  @(posedge clock);
  decode_valid <= 1'b1;
  flush <= issue_flush;
  op <= o;
  op1_sel <= s1;
  op2_sel <= s2;
  src1 <= a;
  src2 <= b;
  imm <= im;
  pc <= p;
  npc_sel <= ns;
  wb_sel <= ws;
  forward_data <= fwd_value;
  @(posedge clock);
  decode_valid <= 1'b0;
  flush <= 1'b0;
endtask

task automatic check_cycle(input logic [31:0] exp_result, input logic [31:0] exp_npc,
                           input logic [31:0] p);
  @(negedge clock);
  check_value("result_valid", 1, result_valid);
  check_value("result", exp_result, result);
  check_value("next_pc", exp_npc, next_pc);
  check_value("redirect", exp_npc != p + 32'd4, redirect);
  check_value("result_pc", p, result_pc);
endtask

task automatic run_muldiv(input exu_op_e o, input logic [31:0] a, input logic [31:0] b);
  logic [31:0] value;
  logic got;
  int cycles;
  got = 1'b0;
  cycles = 0;
  value = '0;
  issue_op(o, sel_reg_value, sel_reg_value, a, b, 32'h0, 32'h1000, npc_seq, wb_alu_result);
  while (!got && cycles < md_cycles) begin
    @(negedge clock);
    cycles++;
    if (result_valid) begin
      got = 1'b1;
      value = result;
    end else begin
      check_value("busy", 1, busy);
      // An add offered while busy must be ignored.
      @(posedge clock);
      decode_valid <= cycles >= 2 && cycles <= 4;
      op <= op_add;
    end
  end
  if (!got) begin
    error_count++;
    $display("No result_valid within %0d cycles for op %0d", md_cycles, o);
  end else begin
    check_value($sformatf("result of op %0d", o), md_model(o, a, b), value);
  end
  @(negedge clock);
  check_value("result_valid after done", 0, result_valid);
  check_value("busy after done", 0, busy);
endtask

task automatic alu_operations();
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] p;
  exu_op_e o;
  for (int r = 0; r < alu_rounds; r++) begin
    for (int i = 0; i <= 16; i++) begin
      o = exu_op_e'(i);
      a = next_rand();
      b = (r == 2) ? a : next_rand();
      p = next_rand() & 32'hffff_fffc;
      if (r % 2 == 1) begin
        issue_op(o, sel_reg_value, sel_immediate, a, next_rand(), b, p, npc_seq, wb_alu_result);
      end else begin
        issue_op(o, sel_reg_value, sel_reg_value, a, b, next_rand(), p, npc_seq, wb_alu_result);
      end
      check_cycle(alu_model(o, a, b), p + 32'd4, p);
    end
  end
endtask

task automatic operand_forwarding();
  logic [31:0] sum;
  logic [31:0] im;
  logic [31:0] p;
  logic [31:0] x;
  p = 32'h0000_2000;
  sum = next_rand();
  issue_op(op_add, sel_reg_value, sel_immediate, sum, next_rand(), 32'h0, p, npc_seq,
           wb_alu_result);
  check_cycle(sum, p + 32'd4, p);
  for (int k = 0; k < fwd_steps; k++) begin
    im = next_rand();
    sum = sum + im;
    // Idle cycles between issues must not disturb the held result.
    if (k == 3) begin
      repeat (2) @(posedge clock);
    end
    issue_op(op_add, sel_self_forward, sel_immediate, next_rand(), next_rand(), im, p,
             npc_seq, wb_alu_result);
    check_cycle(sum, p + 32'd4, p);
  end
  // Back-to-back dependent adds take the live result of the add just ahead.
  im = next_rand();
  sum = sum + im;
  @(posedge clock);
  decode_valid <= 1'b1;
  op <= op_add;
  op1_sel <= sel_self_forward;
  op2_sel <= sel_immediate;
  imm <= im;
  pc <= p;
  npc_sel <= npc_seq;
  wb_sel <= wb_alu_result;
  @(posedge clock);
  for (int k = 1; k < fwd_steps; k++) begin
    im = next_rand();
    imm <= im;
    check_cycle(sum, p + 32'd4, p);
    sum = sum + im;
    @(posedge clock);
  end
  decode_valid <= 1'b0;
  check_cycle(sum, p + 32'd4, p);
  x = next_rand();
  issue_op(op_sub, sel_reg_value, sel_self_forward, x, next_rand(), next_rand(), p, npc_seq,
           wb_alu_result);
  check_cycle(x - sum, p + 32'd4, p);
  fwd_value = next_rand();
  x = next_rand();
  issue_op(op_xor, sel_ext_forward, sel_reg_value, next_rand(), x, next_rand(), p, npc_seq,
           wb_alu_result);
  check_cycle(fwd_value ^ x, p + 32'd4, p);
  issue_op(op_add, sel_reg_value, sel_ext_forward, x, next_rand(), next_rand(), p, npc_seq,
           wb_alu_result);
  check_cycle(x + fwd_value, p + 32'd4, p);
endtask

task automatic control_flow();
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] im;
  logic [31:0] p;
  a = next_rand();
  b = next_rand();
  im = next_rand() & 32'hffff_fffe;
  p = next_rand() & 32'hffff_fffc;
  issue_op(op_add, sel_reg_value, sel_reg_value, a, b, im, p, npc_seq, wb_pc_plus_imm);
  check_cycle(p + im, p + 32'd4, p);
  issue_op(op_add, sel_reg_value, sel_reg_value, a, b, im, p, npc_jal, wb_pc_plus4);
  check_cycle(p + 32'd4, p + im, p);
  issue_op(op_add, sel_reg_value, sel_reg_value, a, b, 32'd4, p, npc_jal, wb_pc_plus4);
  check_cycle(p + 32'd4, p + 32'd4, p);
  issue_op(op_add, sel_reg_value, sel_immediate, a, b, im | 32'h1, p, npc_jalr, wb_pc_plus4);
  check_cycle(p + 32'd4, (a + (im | 32'h1)) & 32'hffff_fffe, p);
  issue_op(op_eq, sel_reg_value, sel_reg_value, a, a, im, p, npc_branch, wb_alu_result);
  check_cycle(32'h1, p + im, p);
  issue_op(op_eq, sel_reg_value, sel_reg_value, a, a ^ 32'h1, im, p, npc_branch,
           wb_alu_result);
  check_cycle(32'h0, p + 32'd4, p);
  issue_op(op_ltu, sel_reg_value, sel_reg_value, a, b, im, p, npc_branch, wb_alu_result);
  check_cycle(alu_model(op_ltu, a, b), (a < b) ? p + im : p + 32'd4, p);
endtask

task automatic multiply_ops();
  for (int r = 0; r < md_rounds; r++) begin
    for (int i = 0; i < 4; i++) begin
      run_muldiv(exu_op_e'(17 + i), next_rand(), next_rand());
    end
  end
endtask

task automatic divide_ops();
  logic [31:0] b;
  logic [31:0] sh;
  for (int r = 0; r < md_rounds; r++) begin
    for (int i = 0; i < 4; i++) begin
      sh = next_rand() % 28;
      b = next_rand() >> sh;
      if (r % 2 == 1) begin
        b = -b;
      end
      run_muldiv(exu_op_e'(21 + i), next_rand(), b);
    end
  end
  for (int i = 0; i < 4; i++) begin
    run_muldiv(exu_op_e'(21 + i), next_rand(), 32'h0);
  end
  run_muldiv(op_div, 32'h8000_0000, 32'hffff_ffff);
  run_muldiv(op_rem, 32'h8000_0000, 32'hffff_ffff);
  run_muldiv(op_divu, 32'h8000_0000, 32'hffff_ffff);
endtask

task automatic flush_behavior();
  logic [31:0] base;
  logic [31:0] im;
  logic [31:0] p;
  p = 32'h0000_3000;
  base = next_rand();
  issue_op(op_add, sel_reg_value, sel_immediate, base, next_rand(), 32'h0, p, npc_seq,
           wb_alu_result);
  check_cycle(base, p + 32'd4, p);
  issue_op(op_mul, sel_reg_value, sel_reg_value, next_rand(), next_rand(), 32'h0, p, npc_seq,
           wb_alu_result);
  repeat (5) @(posedge clock);
  flush <= 1'b1;
  @(posedge clock);
  flush <= 1'b0;
  @(negedge clock);
  check_value("busy after flush", 0, busy);
  repeat (md_cycles) begin
    check_value("result_valid after flush", 0, result_valid);
    @(negedge clock);
  end
  issue_flush = 1'b1;
  issue_op(op_add, sel_reg_value, sel_immediate, next_rand(), next_rand(), next_rand(), p,
           npc_seq, wb_alu_result);
  issue_flush = 1'b0;
  @(negedge clock);
  check_value("result_valid of flushed op", 0, result_valid);
  // The forwarded value is still the last result that was presented as valid.
  im = next_rand();
  issue_op(op_add, sel_self_forward, sel_immediate, next_rand(), next_rand(), im, p,
           npc_seq, wb_alu_result);
  check_cycle(base + im, p + 32'd4, p);
endtask

// ==== verif/exu_tb.sv ====
`timescale 1ns/10ps

module exu_tb;
  import exu_pkg::*;

  localparam int alu_rounds = 4;
  localparam int fwd_steps = 6;
  localparam int md_rounds = 6;
  localparam int md_cycles = muldiv_steps + 8;
  // Bound on the whole run in clock cycles, doubled as margin.
  localparam int budget_cycles = 2 * (3 + alu_rounds * 17 * 3 + (fwd_steps + 4) * 5 + 7 * 3 +
                                      (8 * md_rounds + 8) * (md_cycles + 3) + 3 * md_cycles);

  logic clock;
  logic reset;
  logic decode_valid;
  logic flush;
  logic [31:0] pc;
  logic [31:0] imm;
  logic [31:0] src1;
  logic [31:0] src2;
  logic [31:0] forward_data;
  exu_op_e op;
  operand_sel_e op1_sel;
  operand_sel_e op2_sel;
  npc_sel_e npc_sel;
  wb_sel_e wb_sel;
  logic busy;
  logic result_valid;
  logic redirect;
  logic [31:0] result;
  logic [31:0] next_pc;
  logic [31:0] result_pc;

  logic [31:0] seed;
  int error_count;
  int check_count;
  logic issue_flush;
  logic [31:0] fwd_value;

  exu_top i_dut (
    .clock        (clock),
    .reset        (reset),
    .decode_valid (decode_valid),
    .flush        (flush),
    .pc           (pc),
    .imm          (imm),
    .src1         (src1),
    .src2         (src2),
    .forward_data (forward_data),
    .op           (op),
    .op1_sel      (op1_sel),
    .op2_sel      (op2_sel),
    .npc_sel      (npc_sel),
    .wb_sel       (wb_sel),
    .busy         (busy),
    .result_valid (result_valid),
    .redirect     (redirect),
    .result       (result),
    .next_pc      (next_pc),
    .result_pc    (result_pc)
  );

  always #4 clock = ~clock;

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] alu_model(exu_op_e o, logic [31:0] a, logic [31:0] b);
    logic [4:0] sh;
    logic lt_s;
    logic lt_u;
    sh = b[4:0];
    lt_s = $signed(a) < $signed(b);
    lt_u = a < b;
    case (o)
      op_add:    return a + b;
      op_sub:    return a - b;
      op_sll:    return a << sh;
      op_slt:    return {31'b0, lt_s};
      op_sltu:   return {31'b0, lt_u};
      op_xor:    return a ^ b;
      op_srl:    return a >> sh;
      op_sra:    return $signed(a) >>> sh;
      op_or:     return a | b;
      op_and:    return a & b;
      op_eq:     return {31'b0, a == b};
      op_ne:     return {31'b0, a != b};
      op_lt:     return {31'b0, lt_s};
      op_ge:     return {31'b0, !lt_s};
      op_ltu:    return {31'b0, lt_u};
      op_geu:    return {31'b0, !lt_u};
      op_pass_b: return b;
      default:   return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] md_model(exu_op_e o, logic [31:0] a, logic [31:0] b);
    logic [63:0] p_uu;
    logic [63:0] p_ss;
    logic [63:0] p_su;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic signed [31:0] q_s;
    logic signed [31:0] r_s;
    logic [31:0] q_u;
    logic [31:0] r_u;
    logic ovf;
    // Products taken modulo 2^64 carry the right bits for every sign mix.
    p_uu = {32'b0, a} * {32'b0, b};
    p_ss = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    p_su = {{32{a[31]}}, a} * {32'b0, b};
    sa = a;
    sb = b;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    q_s = 0;
    r_s = 0;
    q_u = 0;
    r_u = 0;
    if (b != 0 && !ovf) begin
      q_s = sa / sb;
      r_s = sa % sb;
    end
    if (b != 0) begin
      q_u = a / b;
      r_u = a % b;
    end
    case (o)
      op_mul:    return p_uu[31:0];
      op_mulh:   return p_ss[63:32];
      op_mulhsu: return p_su[63:32];
      op_mulhu:  return p_uu[63:32];
      op_div:    return (b == 0) ? 32'hffff_ffff : (ovf ? a : q_s);
      op_divu:   return (b == 0) ? 32'hffff_ffff : q_u;
      op_rem:    return (b == 0) ? a : (ovf ? 32'h0 : r_s);
      op_remu:   return (b == 0) ? a : r_u;
      default:   return 32'h0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED: %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  `include "exu_tb_tests.svh"

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    decode_valid = 1'b0;
    flush = 1'b0;
    pc = '0;
    imm = '0;
    src1 = '0;
    src2 = '0;
    forward_data = '0;
    op = op_add;
    op1_sel = sel_reg_value;
    op2_sel = sel_reg_value;
    npc_sel = npc_seq;
    wb_sel = wb_alu_result;
    seed = 32'h64c040c5;
    error_count = 0;
    check_count = 0;
    issue_flush = 1'b0;
    fwd_value = '0;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    alu_operations();
    operand_forwarding();
    control_flow();
    multiply_ops();
    divide_ops();
    flush_behavior();
    @(posedge clock);
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(budget_cycles * 8);
    $display("Timeout: the tests did not finish within %0d clock cycles", budget_cycles);
    $display("%0d checks, %0d errors", check_count, error_count);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+verif
src/exu_pkg.sv
src/exu_issue_if.sv
src/exu_operand_select.sv
src/exu_alu.sv
src/exu_next_pc.sv
src/exu_muldiv_fsm.sv
src/exu_step_counter.sv
src/exu_muldiv_datapath.sv
src/exu_top.sv
verif/exu_tb.sv
